//--- src/mem_pkg.sv
package mem_pkg;

    localparam int PAGE_BITS   = 8;    // 256 byte pages
    localparam int VPN_W       = 24;
    localparam int PFN_W       = 24;
    localparam int TLB_ENTRIES = 4;
    localparam int TLB_IDX_W   = 2;
    localparam int RAM_WORDS   = 256;
    localparam int RAM_IDX_W   = 8;    // word index, paddr bits 9..2

    typedef enum logic [2:0] {
        OP_LW  = 3'd0,
        OP_LH  = 3'd1,
        OP_LHU = 3'd2,
        OP_LB  = 3'd3,
        OP_LBU = 3'd4,
        OP_SW  = 3'd5,
        OP_SH  = 3'd6,
        OP_SB  = 3'd7
    } mem_op_e;

    typedef enum logic [4:0] {
        EXC_NONE = 5'd0,
        EXC_MOD  = 5'd1,   // store to clean page
        EXC_TLBL = 5'd2,
        EXC_TLBS = 5'd3,
        EXC_ADEL = 5'd4,
        EXC_ADES = 5'd5
    } exc_code_e;

    typedef struct packed {
        logic [VPN_W-1:0] vpn;
        logic [PFN_W-1:0] pfn;
        logic             v;
        logic             d;
    } tlb_entry_t;

    typedef struct packed {
        mem_op_e     op;
        logic [31:0] vaddr;
        logic [31:0] wdata;
    } mem_req_t;

    typedef struct packed {
        mem_op_e     op;
        logic [31:0] vaddr;
        logic [31:0] rdata;
        exc_code_e   exc;
    } m1_to_wb_t;

    function automatic logic is_store(mem_op_e op);
        return op inside {OP_SW, OP_SH, OP_SB};
    endfunction

endpackage

//--- src/dmem_if.sv
`timescale 1ns/1ns

interface dmem_if;
    // request side, driven by the memory stage
    logic        req;
    logic        we;
    logic [3:0]  wstrb;
    logic [31:0] paddr;
    logic [31:0] wdata;
    // response side, driven by the data memory
    logic        addr_ok;
    logic        data_ok;
    logic [31:0] rdata;

    modport cpu (
        output req, we, wstrb, paddr, wdata,
        input  addr_ok, data_ok, rdata
    );

    modport mem (
        input  req, we, wstrb, paddr, wdata,
        output addr_ok, data_ok, rdata
    );

endinterface

//--- src/dtlb_lookup.sv
`timescale 1ns/1ns

module dtlb_lookup (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         we,
    input  logic [mem_pkg::TLB_IDX_W-1:0] windex,
    input  mem_pkg::tlb_entry_t          wentry,
    input  logic [mem_pkg::VPN_W-1:0]    vpn,
    output logic                         hit,
    output logic [mem_pkg::PFN_W-1:0]    pfn,
    output logic                         v,
    output logic                         d
);
    import mem_pkg::*;

    tlb_entry_t             entries [TLB_ENTRIES];
    logic [TLB_ENTRIES-1:0] match;
    logic [TLB_ENTRIES-1:0] valid_match;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < TLB_ENTRIES; i++) begin
                entries[i] <= '0;   // v cleared, no page mapped
            end
        end else if (we) begin
            entries[windex] <= wentry;
        end
    end

    // parallel compare, invalid entries still count as a hit
    always_comb begin
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            match[i]       = (entries[i].vpn == vpn);
            valid_match[i] = match[i] && entries[i].v;
        end
    end

    // lowest index wins
    always_comb begin
        hit = 1'b0;
        pfn = '0;
        v   = 1'b0;
        d   = 1'b0;
        for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
            if (match[i]) begin
                hit = 1'b1;
                pfn = entries[i].pfn;
                v   = entries[i].v;
                d   = entries[i].d;
            end
        end
    end

    // software must never map one page twice
    a_no_double_map: assert property (@(posedge clk) disable iff (reset)
        $onehot0(valid_match));

endmodule

//--- src/mem_stage.sv
`timescale 1ns/1ns

module mem_stage (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      in_valid,
    output logic                      in_allowin,
    input  mem_pkg::mem_req_t         in_req,
    output logic [mem_pkg::VPN_W-1:0] tlb_vpn,
    input  logic                      tlb_hit,
    input  logic [mem_pkg::PFN_W-1:0] tlb_pfn,
    input  logic                      tlb_v,
    input  logic                      tlb_d,
    dmem_if.cpu                       dmem,
    output logic                      m1_valid,
    input  logic                      wb_allowin,
    output mem_pkg::m1_to_wb_t        m1_to_wb
);
    import mem_pkg::*;

    logic        stage_valid;
    mem_req_t    req_r;
    logic        sent;          // request already accepted by memory
    logic        done;          // response parked in rdata_hold
    logic [31:0] rdata_hold;
    logic        store;
    logic        misaligned;
    exc_code_e   exc_now;
    exc_code_e   exc_cur;
    logic        ready_go;
    logic        leave;

    assign store   = is_store(req_r.op);
    assign tlb_vpn = req_r.vaddr[31:PAGE_BITS];

    always_comb begin
        case (req_r.op)
            OP_LW, OP_SW:         misaligned = (req_r.vaddr[1:0] != 2'b00);
            OP_LH, OP_LHU, OP_SH: misaligned = req_r.vaddr[0];
            default:              misaligned = 1'b0;
        endcase
    end

    // alignment first, then miss/invalid, then dirty check
    always_comb begin
        if (misaligned)
            exc_now = store ? EXC_ADES : EXC_ADEL;
        else if (!tlb_hit || !tlb_v)
            exc_now = store ? EXC_TLBS : EXC_TLBL;
        else if (store && !tlb_d)
            exc_now = EXC_MOD;
        else
            exc_now = EXC_NONE;
    end

    // an issued op is committed and ignores later TLB writes
    assign exc_cur    = sent ? EXC_NONE : exc_now;
    assign ready_go   = (exc_cur != EXC_NONE) || dmem.data_ok || done;
    assign in_allowin = !stage_valid || (ready_go && wb_allowin);
    assign m1_valid   = stage_valid && ready_go;
    assign leave      = m1_valid && wb_allowin;

    always_ff @(posedge clk) begin
        if (reset)
            stage_valid <= 1'b0;
        else if (in_allowin)
            stage_valid <= in_valid;
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_allowin)
            req_r <= in_req;
        if (dmem.data_ok)
            rdata_hold <= dmem.rdata;
    end

    always_ff @(posedge clk) begin
        if (reset || leave) begin
            sent <= 1'b0;
            done <= 1'b0;
        end else begin
            if (dmem.req && dmem.addr_ok)
                sent <= 1'b1;
            if (dmem.data_ok)
                done <= 1'b1;   // word kept while writeback is full
        end
    end

    assign dmem.req   = stage_valid && (exc_now == EXC_NONE) && !sent;
    assign dmem.we    = store;
    assign dmem.paddr = {tlb_pfn, req_r.vaddr[PAGE_BITS-1:0]};

    always_comb begin
        case (req_r.op)
            OP_SW: begin
                dmem.wstrb = 4'b1111;
                dmem.wdata = req_r.wdata;
            end
            OP_SH: begin
                dmem.wstrb = 4'b0011 << {req_r.vaddr[1], 1'b0};
                dmem.wdata = {2{req_r.wdata[15:0]}};
            end
            OP_SB: begin
                dmem.wstrb = 4'b0001 << req_r.vaddr[1:0];
                dmem.wdata = {4{req_r.wdata[7:0]}};
            end
            default: begin
                dmem.wstrb = 4'b0000;  // loads
                dmem.wdata = req_r.wdata;
            end
        endcase
    end

    always_comb begin
        m1_to_wb.op    = req_r.op;
        m1_to_wb.vaddr = req_r.vaddr;
        m1_to_wb.rdata = done ? rdata_hold : dmem.rdata;
        m1_to_wb.exc   = exc_cur;
    end

    // req only for an aligned access to a mapped, valid and writable page
    a_exc_no_access: assert property (@(posedge clk) disable iff (reset)
        dmem.req |-> !misaligned && tlb_hit && tlb_v && (!store || tlb_d));

    a_exc_no_response: assert property (@(posedge clk) disable iff (reset)
        (stage_valid && exc_cur != EXC_NONE) |-> !dmem.data_ok);

    a_load_no_strobe: assert property (@(posedge clk) disable iff (reset)
        !dmem.we |-> (dmem.wstrb == 4'b0000));

endmodule

//--- src/data_ram.sv
`timescale 1ns/1ns

module data_ram (
    input logic clk,
    input logic reset,
    dmem_if.mem dmem
);
    import mem_pkg::*;

    logic [31:0]          ram [RAM_WORDS];
    logic                 accept;
    logic [RAM_IDX_W-1:0] idx;
    logic                 data_ok_r;
    logic [31:0]          rdata_r;

    assign idx    = dmem.paddr[RAM_IDX_W+1:2];
    assign accept = dmem.req && dmem.addr_ok;

    // busy for the one response cycle
    assign dmem.addr_ok = !data_ok_r;
    assign dmem.data_ok = data_ok_r;
    assign dmem.rdata   = rdata_r;

    always_ff @(posedge clk) begin
        if (reset)
            data_ok_r <= 1'b0;
        else
            data_ok_r <= accept;
    end

    always_ff @(posedge clk) begin
        if (accept)
            rdata_r <= ram[idx];  // old word, also for stores
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < RAM_WORDS; i++) begin
                ram[i] <= '0;
            end
        end else if (accept && dmem.we) begin
            for (int b = 0; b < 4; b++) begin
                if (dmem.wstrb[b])
                    ram[idx][8*b +: 8] <= dmem.wdata[8*b +: 8];
            end
        end
    end

    // no response without a request accepted the cycle before
    a_data_ok_follows_req: assert property (@(posedge clk) disable iff (reset)
        dmem.data_ok |-> $past(dmem.req && dmem.addr_ok));

endmodule

//--- src/wb_stage.sv
`timescale 1ns/1ns

module wb_stage (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 m1_valid,
    output logic                 wb_allowin,
    input  mem_pkg::m1_to_wb_t   m1_to_wb,
    output logic                 out_valid,
    input  logic                 out_ready,
    output mem_pkg::mem_op_e     out_op,
    output logic [31:0]          out_result,
    output mem_pkg::exc_code_e   out_exc,
    output logic [31:0]          out_exc_vaddr
);
    import mem_pkg::*;

    logic [7:0]  byte_sel;
    logic [15:0] half_sel;
    logic [31:0] result;
    logic        has_exc;

    assign has_exc    = (m1_to_wb.exc != EXC_NONE);
    assign wb_allowin = !out_valid || out_ready;

    assign byte_sel = m1_to_wb.rdata[8*m1_to_wb.vaddr[1:0] +: 8];
    assign half_sel = m1_to_wb.rdata[16*m1_to_wb.vaddr[1] +: 16];

    always_comb begin
        if (has_exc) begin
            result = '0;
        end else begin
            case (m1_to_wb.op)
                OP_LW:   result = m1_to_wb.rdata;
                OP_LH:   result = {{16{half_sel[15]}}, half_sel};
                OP_LHU:  result = {16'b0, half_sel};
                OP_LB:   result = {{24{byte_sel[7]}}, byte_sel};
                OP_LBU:  result = {24'b0, byte_sel};
                default: result = '0;   // stores
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset)
            out_valid <= 1'b0;
        else if (wb_allowin)
            out_valid <= m1_valid;
    end

    always_ff @(posedge clk) begin
        if (m1_valid && wb_allowin) begin
            out_op        <= m1_to_wb.op;
            out_result    <= result;
            out_exc       <= m1_to_wb.exc;
            out_exc_vaddr <= has_exc ? m1_to_wb.vaddr : 32'b0;
        end
    end

    a_hold_when_stalled: assert property (@(posedge clk) disable iff (reset)
        (out_valid && !out_ready) |=> out_valid && $stable(out_op)
            && $stable(out_result) && $stable(out_exc) && $stable(out_exc_vaddr));

endmodule

//--- src/mem_subsys_top.sv
`timescale 1ns/1ns

module mem_subsys_top (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          in_valid,
    output logic                          in_allowin,
    input  mem_pkg::mem_op_e              in_op,
    input  logic [31:0]                   in_vaddr,
    input  logic [31:0]                   in_wdata,
    output logic                          out_valid,
    input  logic                          out_ready,
    output mem_pkg::mem_op_e              out_op,
    output logic [31:0]                   out_result,
    output mem_pkg::exc_code_e            out_exc,
    output logic [31:0]                   out_exc_vaddr,
    input  logic                          tlb_we,
    input  logic [mem_pkg::TLB_IDX_W-1:0] tlb_index,
    input  logic [mem_pkg::VPN_W-1:0]     tlb_vpn,
    input  logic [mem_pkg::PFN_W-1:0]     tlb_pfn,
    input  logic                          tlb_v,
    input  logic                          tlb_d
);
    import mem_pkg::*;

    mem_req_t          in_req;
    tlb_entry_t        tlb_wentry;
    logic [VPN_W-1:0]  lookup_vpn;
    logic              lookup_hit;
    logic [PFN_W-1:0]  lookup_pfn;
    logic              lookup_v;
    logic              lookup_d;
    logic              m1_valid;
    logic              wb_allowin;
    m1_to_wb_t         m1_to_wb;

    assign in_req     = '{op: in_op, vaddr: in_vaddr, wdata: in_wdata};
    assign tlb_wentry = '{vpn: tlb_vpn, pfn: tlb_pfn, v: tlb_v, d: tlb_d};

    dmem_if u_dmem_if ();

    dtlb_lookup u_dtlb (
        .clk    (clk),
        .reset  (reset),
        .we     (tlb_we),
        .windex (tlb_index),
        .wentry (tlb_wentry),
        .vpn    (lookup_vpn),
        .hit    (lookup_hit),
        .pfn    (lookup_pfn),
        .v      (lookup_v),
        .d      (lookup_d)
    );

    mem_stage u_mem_stage (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .in_allowin (in_allowin),
        .in_req     (in_req),
        .tlb_vpn    (lookup_vpn),
        .tlb_hit    (lookup_hit),
        .tlb_pfn    (lookup_pfn),
        .tlb_v      (lookup_v),
        .tlb_d      (lookup_d),
        .dmem       (u_dmem_if.cpu),
        .m1_valid   (m1_valid),
        .wb_allowin (wb_allowin),
        .m1_to_wb   (m1_to_wb)
    );

    data_ram u_data_ram (
        .clk   (clk),
        .reset (reset),
        .dmem  (u_dmem_if.mem)
    );

    wb_stage u_wb_stage (
        .clk           (clk),
        .reset         (reset),
        .m1_valid      (m1_valid),
        .wb_allowin    (wb_allowin),
        .m1_to_wb      (m1_to_wb),
        .out_valid     (out_valid),
        .out_ready     (out_ready),
        .out_op        (out_op),
        .out_result    (out_result),
        .out_exc       (out_exc),
        .out_exc_vaddr (out_exc_vaddr)
    );

endmodule

//--- testbench/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// one compare task per result kind, all stop at the first mismatch

task automatic check_result(string name, logic [31:0] exp, logic [31:0] act);
    if (act !== exp)
        abort_run($sformatf("CHECK FAILED %s result: expected %h, actual %h",
            name, exp, act));
endtask

task automatic check_exc(string name, exc_code_e exp, exc_code_e act);
    if (act !== exp)
        abort_run($sformatf("CHECK FAILED %s exc: expected %s (%0d), actual %s (%0d)",
            name, exp.name(), exp, act.name(), act));
endtask

task automatic check_op(string name, mem_op_e exp, mem_op_e act);
    if (act !== exp)
        abort_run($sformatf("CHECK FAILED %s op: expected %s (%0d), actual %s (%0d)",
            name, exp.name(), exp, act.name(), act));
endtask

task automatic check_vaddr(string name, logic [31:0] exp, logic [31:0] act);
    if (act !== exp)
        abort_run($sformatf("CHECK FAILED %s exc_vaddr: expected %h, actual %h",
            name, exp, act));
endtask

`endif

//--- testbench/tb_mem_subsys.sv
`timescale 1ns/1ns

module tb_mem_subsys;
    import mem_pkg::*;

    localparam int DRIVE_DLY = 5;   // inputs change this long after the rising edge

    typedef struct packed {
        logic                 is_tlb;
        logic [TLB_IDX_W-1:0] idx;
        logic [VPN_W-1:0]     vpn;
        logic [PFN_W-1:0]     pfn;
        logic                 v;
        logic                 d;
        mem_op_e              op;
        logic [31:0]          vaddr;
        logic [31:0]          wdata;
        logic [31:0]          exp_result;
        exc_code_e            exp_exc;
    } row_t;

    logic                 clk;
    logic                 reset;
    logic                 in_valid;
    logic                 in_allowin;
    mem_op_e              in_op;
    logic [31:0]          in_vaddr;
    logic [31:0]          in_wdata;
    logic                 out_valid;
    logic                 out_ready;
    mem_op_e              out_op;
    logic [31:0]          out_result;
    exc_code_e            out_exc;
    logic [31:0]          out_exc_vaddr;
    logic                 tlb_we;
    logic [TLB_IDX_W-1:0] tlb_index;
    logic [VPN_W-1:0]     tlb_vpn;
    logic [PFN_W-1:0]     tlb_pfn;
    logic                 tlb_v;
    logic                 tlb_d;

    row_t        rows[$];
    string       names[$];
    int          exp_q[$];      // row indices in flight in issue order
    int          cycles = 0;
    int          limit;
    int          mon_idx;
    logic [31:0] rng_state;

    mem_subsys_top u_dut (.*);

    initial clk = 1'b0;
    always #50 clk = ~clk;

    task automatic abort_run(string what);
        $display("%s", what);
        $display("Regression failed");
        $fatal(1, "stopped at first error");
    endtask

    `include "tb_checks.svh"

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    task automatic add_tlb(string name, int idx, int vpn, int pfn, bit v, bit d);
        row_t r;
        r = '0;
        r.is_tlb = 1'b1;
        r.idx    = idx;
        r.vpn    = vpn;
        r.pfn    = pfn;
        r.v      = v;
        r.d      = d;
        rows.push_back(r);
        names.push_back(name);
    endtask

    task automatic add_op(string name, mem_op_e op, logic [31:0] vaddr,
                          logic [31:0] wdata, logic [31:0] res, exc_code_e exc);
        row_t r;
        r = '0;
        r.op         = op;
        r.vaddr      = vaddr;
        r.wdata      = wdata;
        r.exp_result = res;
        r.exp_exc    = exc;
        rows.push_back(r);
        names.push_back(name);
    endtask

    // scratch word in physical page 1 that is never read back
    task automatic add_filler(string name);
        add_op(name, OP_SW, 32'h000020fc, next_rand(), 32'h0, EXC_NONE);
    endtask

    task automatic build_table();
        add_tlb("map_v10_p0", 0, 'h10, 'h0, 1, 1);
        add_tlb("map_v20_p1", 1, 'h20, 'h1, 1, 1);
        add_tlb("map_v30_p4", 2, 'h30, 'h4, 1, 1);   // pfn 4 aliases page 0
        add_tlb("map_v40_clean", 3, 'h40, 'h2, 1, 0);
        add_op("sw_p0", OP_SW, 32'h00001004, 32'hcafef00d, 32'h0, EXC_NONE);
        add_op("lw_p0", OP_LW, 32'h00001004, 32'h0, 32'hcafef00d, EXC_NONE);
        add_op("lw_alias", OP_LW, 32'h00003004, 32'h0, 32'hcafef00d, EXC_NONE);
        add_op("sw_p1", OP_SW, 32'h00002008, 32'h12345678, 32'h0, EXC_NONE);
        add_op("lw_p1", OP_LW, 32'h00002008, 32'h0, 32'h12345678, EXC_NONE);
        add_op("lw_p0_untouched", OP_LW, 32'h00001008, 32'h0, 32'h0, EXC_NONE);
        add_filler("filler_a");
        // byte lanes with junk in the upper wdata bits
        add_op("sb_0", OP_SB, 32'h00001010, 32'h11223381, 32'h0, EXC_NONE);
        add_op("sb_1", OP_SB, 32'h00001011, 32'h0000007f, 32'h0, EXC_NONE);
        add_op("sb_2", OP_SB, 32'h00001012, 32'hffffffa5, 32'h0, EXC_NONE);
        add_op("sb_3", OP_SB, 32'h00001013, 32'h0000003c, 32'h0, EXC_NONE);
        add_op("lw_bytes", OP_LW, 32'h00001010, 32'h0, 32'h3ca57f81, EXC_NONE);
        add_op("lb_0", OP_LB, 32'h00001010, 32'h0, 32'hffffff81, EXC_NONE);
        add_op("lbu_0", OP_LBU, 32'h00001010, 32'h0, 32'h00000081, EXC_NONE);
        add_op("lb_1", OP_LB, 32'h00001011, 32'h0, 32'h0000007f, EXC_NONE);
        add_op("lb_2", OP_LB, 32'h00001012, 32'h0, 32'hffffffa5, EXC_NONE);
        add_op("lbu_2", OP_LBU, 32'h00001012, 32'h0, 32'h000000a5, EXC_NONE);
        add_op("lb_3", OP_LB, 32'h00001013, 32'h0, 32'h0000003c, EXC_NONE);
        add_op("lh_bytes", OP_LH, 32'h00001010, 32'h0, 32'h00007f81, EXC_NONE);
        add_op("lhu_bytes", OP_LHU, 32'h00001012, 32'h0, 32'h00003ca5, EXC_NONE);
        add_op("sh_0", OP_SH, 32'h00001014, 32'habcd8001, 32'h0, EXC_NONE);
        add_op("sh_2", OP_SH, 32'h00001016, 32'h1234f00f, 32'h0, EXC_NONE);
        add_op("lw_halves", OP_LW, 32'h00001014, 32'h0, 32'hf00f8001, EXC_NONE);
        add_op("lh_0", OP_LH, 32'h00001014, 32'h0, 32'hffff8001, EXC_NONE);
        add_op("lhu_0", OP_LHU, 32'h00001014, 32'h0, 32'h00008001, EXC_NONE);
        add_op("lh_2", OP_LH, 32'h00001016, 32'h0, 32'hfffff00f, EXC_NONE);
        add_op("lhu_2", OP_LHU, 32'h00001016, 32'h0, 32'h0000f00f, EXC_NONE);
        add_filler("filler_b");
        // misaligned accesses
        add_op("lw_mis1", OP_LW, 32'h00001011, 32'h0, 32'h0, EXC_ADEL);
        add_op("lw_mis2", OP_LW, 32'h00001012, 32'h0, 32'h0, EXC_ADEL);
        add_op("lh_mis", OP_LH, 32'h00001013, 32'h0, 32'h0, EXC_ADEL);
        add_op("lhu_mis", OP_LHU, 32'h00001011, 32'h0, 32'h0, EXC_ADEL);
        add_op("sw_mis", OP_SW, 32'h00001012, 32'hdeadbeef, 32'h0, EXC_ADES);
        add_op("sh_mis", OP_SH, 32'h00001015, 32'h0000beef, 32'h0, EXC_ADES);
        add_op("lw_after_ades", OP_LW, 32'h00001010, 32'h0, 32'h3ca57f81, EXC_NONE);
        add_op("lw_after_ades2", OP_LW, 32'h00001014, 32'h0, 32'hf00f8001, EXC_NONE);
        // TLB misses and permissions
        add_op("lw_unmapped", OP_LW, 32'h00005000, 32'h0, 32'h0, EXC_TLBL);
        add_op("sw_unmapped", OP_SW, 32'h00005000, 32'h1, 32'h0, EXC_TLBS);
        add_op("lb_unmapped", OP_LB, 32'h00005003, 32'h0, 32'h0, EXC_TLBL);
        add_op("lw_mis_unmapped", OP_LW, 32'h00005002, 32'h0, 32'h0, EXC_ADEL);
        add_op("lw_clean", OP_LW, 32'h00004000, 32'h0, 32'h0, EXC_NONE);
        add_op("sw_clean", OP_SW, 32'h00004000, 32'h55aa55aa, 32'h0, EXC_MOD);
        add_op("sb_clean", OP_SB, 32'h00004001, 32'h000000ff, 32'h0, EXC_MOD);
        add_op("sh_mis_clean", OP_SH, 32'h00004001, 32'h0000ffff, 32'h0, EXC_ADES);
        add_op("lw_clean_after", OP_LW, 32'h00004000, 32'h0, 32'h0, EXC_NONE);
        add_tlb("inval_v40", 3, 'h40, 'h2, 0, 0);   // invalid and clean
        add_op("lw_invalid", OP_LW, 32'h00004000, 32'h0, 32'h0, EXC_TLBL);
        add_op("sw_invalid", OP_SW, 32'h00004000, 32'h77777777, 32'h0, EXC_TLBS);
        add_op("lbu_invalid", OP_LBU, 32'h00004002, 32'h0, 32'h0, EXC_TLBL);
        // rewrite entry 0 towards page 1
        add_tlb("remap_v10_p1", 0, 'h10, 'h1, 1, 1);
        add_op("lw_remap", OP_LW, 32'h00001008, 32'h0, 32'h12345678, EXC_NONE);
        add_op("lw_remap2", OP_LW, 32'h00001004, 32'h0, 32'h0, EXC_NONE);
        add_op("lw_alias_old", OP_LW, 32'h00003004, 32'h0, 32'hcafef00d, EXC_NONE);
        add_tlb("remap_v40_dirty", 3, 'h40, 'h2, 1, 1);
        add_op("lw_v40", OP_LW, 32'h00004000, 32'h0, 32'h0, EXC_NONE);
        add_op("sw_v40", OP_SW, 32'h00004000, 32'ha5a5a5a5, 32'h0, EXC_NONE);
        add_op("lw_v40_back", OP_LW, 32'h00004000, 32'h0, 32'ha5a5a5a5, EXC_NONE);
        add_filler("filler_c");
        add_filler("filler_d");
        add_filler("filler_e");
    endtask

    // TLB writes wait for an empty pipeline so no op sees a half-changed mapping
    task automatic write_tlb(row_t r);
        while (exp_q.size() != 0) begin
            @(posedge clk);
            #DRIVE_DLY;
        end
        tlb_we    = 1'b1;
        tlb_index = r.idx;
        tlb_vpn   = r.vpn;
        tlb_pfn   = r.pfn;
        tlb_v     = r.v;
        tlb_d     = r.d;
        @(posedge clk);
        #DRIVE_DLY;
        tlb_we = 1'b0;
    endtask

    task automatic send_op(int i);
        in_valid = 1'b1;
        in_op    = rows[i].op;
        in_vaddr = rows[i].vaddr;
        in_wdata = rows[i].wdata;
        @(posedge clk);
        while (!in_allowin)
            @(posedge clk);
        exp_q.push_back(i);   // transferred on this edge
        #DRIVE_DLY;
        in_valid = 1'b0;
    endtask

    // ready roughly 3 cycles out of 4
    always @(posedge clk) begin
        #DRIVE_DLY;
        out_ready = (next_rand() & 32'h3) != 0;
    end

    always @(posedge clk) begin
        if (!reset && out_valid && out_ready) begin
            if (exp_q.size() == 0) begin
                abort_run("an output appeared with no operation outstanding");
            end else begin
                mon_idx = exp_q.pop_front();
                check_op(names[mon_idx], rows[mon_idx].op, out_op);
                check_result(names[mon_idx], rows[mon_idx].exp_result, out_result);
                check_exc(names[mon_idx], rows[mon_idx].exp_exc, out_exc);
                check_vaddr(names[mon_idx],
                    (rows[mon_idx].exp_exc != EXC_NONE) ? rows[mon_idx].vaddr : 32'h0,
                    out_exc_vaddr);
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit)
            abort_run($sformatf("timeout, results still missing after %0d cycles", cycles));
    end

    initial begin
        rng_state = 32'he3fcf966;
        reset     = 1'b1;
        in_valid  = 1'b0;
        in_op     = OP_LW;
        in_vaddr  = 32'h0;
        in_wdata  = 32'h0;
        out_ready = 1'b0;
        tlb_we    = 1'b0;
        tlb_index = '0;
        tlb_vpn   = '0;
        tlb_pfn   = '0;
        tlb_v     = 1'b0;
        tlb_d     = 1'b0;
        build_table();
        limit = 8 * rows.size() + 100;
        repeat (10) @(posedge clk);
        #DRIVE_DLY;
        reset = 1'b0;
        foreach (rows[i]) begin
            if (rows[i].is_tlb)
                write_tlb(rows[i]);
            else
                send_op(i);
        end
        while (exp_q.size() != 0)
            @(posedge clk);
        #DRIVE_DLY;
        if (out_valid) begin
            abort_run("a result came out after the last expected one");
        end else begin
            $display("Regression passed");
            $finish;
        end
    end

endmodule

//--- tb.f
+incdir+testbench
src/mem_pkg.sv
src/dmem_if.sv
src/dtlb_lookup.sv
src/mem_stage.sv
src/data_ram.sv
src/wb_stage.sv
src/mem_subsys_top.sv
testbench/tb_mem_subsys.sv

//--- Bender.yml
package:
  name: mem_subsys

sources:
  - src/mem_pkg.sv
  - src/dmem_if.sv
  - src/dtlb_lookup.sv
  - src/mem_stage.sv
  - src/data_ram.sv
  - src/wb_stage.sv
  - src/mem_subsys_top.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_mem_subsys.sv
